//--- hw/cp0_cfg.svh
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

// CP0 register numbers, select 0 only
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// Shared restart address, BEV=1 general vector
`define CP0_EXC_VECTOR   32'hBFC00380

// Read-only identification
`define CP0_PRID_VALUE   32'h00004220
`define CP0_CONFIG_VALUE 32'h80008082

// BEV set, everything else clear
`define CP0_STATUS_RESET 32'h00400000

// Software-writable bits
// Status: IM[15:8], EXL, IE
`define CP0_STATUS_WMASK 32'h0000FF03
// Cause: IV, WP, IP[9:8]
`define CP0_CAUSE_WMASK  32'h00C00300

`endif

//--- hw/cp0_pkg.sv
package cp0_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  cp0_addr_t;
    typedef logic [5:0]  hw_int_t;

    // Resolved event of one memory-stage instruction
    typedef enum logic [3:0] {
        EXC_NONE    = 4'd0,
        EXC_INT     = 4'd1,
        EXC_ADEL_IF = 4'd2,
        EXC_ADEL    = 4'd3,
        EXC_ADES    = 4'd4,
        EXC_SYS     = 4'd5,
        EXC_BP      = 4'd6,
        EXC_RI      = 4'd7,
        EXC_OV      = 4'd8,
        EXC_TR      = 4'd9,
        EXC_ERET    = 4'd10
    } exc_type_t;

    // Cause.ExcCode field
    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12,
        TR   = 5'd13
    } exc_code_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  in_delay_slot;
        word_t mem_addr;
        logic  adel_if;
        logic  adel;
        logic  ades;
        logic  syscall;
        logic  brk;
        logic  ri;
        logic  ov;
        logic  trap;
        logic  eret;
    } mem_exc_t;

    typedef struct packed {
        logic      we;
        cp0_addr_t addr;
        word_t     data;
    } cp0_wr_t;

    typedef struct packed {
        exc_type_t kind;
        word_t     pc;
        logic      in_delay_slot;
        word_t     bad_addr;
    } exc_event_t;

endpackage

//--- hw/cp0_reg.sv
`timescale 1ns/1ns

`include "cp0_cfg.svh"

module cp0_reg
    import cp0_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  hw_int_t    int_i,
    input  cp0_wr_t    wr_i,
    input  cp0_addr_t  raddr_i,
    input  exc_event_t event_i,
    output word_t      rdata_o,
    output word_t      status_o,
    output word_t      cause_o,
    output word_t      epc_o,
    output logic       timer_int_o
);

    word_t count_q;
    word_t compare_q;
    word_t status_q;
    word_t cause_q;
    word_t epc_q;
    word_t badvaddr_q;
    logic  timer_int_q;

    logic      take_exc;
    logic      load_badvaddr;
    logic      write_count;
    logic      write_compare;
    logic      timer_hit;
    exc_code_t exc_code;
    word_t     epc_exc;

    function automatic exc_code_t code_of(input exc_type_t kind);
        exc_code_t code;
        case (kind)
            EXC_INT:     code = INT;
            EXC_ADEL_IF: code = ADEL;
            EXC_ADEL:    code = ADEL;
            EXC_ADES:    code = ADES;
            EXC_SYS:     code = SYS;
            EXC_BP:      code = BP;
            EXC_RI:      code = RI;
            EXC_OV:      code = OV;
            EXC_TR:      code = TR;
            default:     code = INT;
        endcase
        return code;
    endfunction

    assign take_exc = (event_i.kind != EXC_NONE) && (event_i.kind != EXC_ERET);

    assign load_badvaddr = (event_i.kind == EXC_ADEL_IF) ||
                           (event_i.kind == EXC_ADEL) ||
                           (event_i.kind == EXC_ADES);

    assign exc_code = code_of(event_i.kind);

    // Branch in flight, so restart at the branch
    assign epc_exc = event_i.in_delay_slot ? (event_i.pc - 32'd4) : event_i.pc;

    assign write_count   = wr_i.we && (wr_i.addr == `CP0_REG_COUNT);
    assign write_compare = wr_i.we && (wr_i.addr == `CP0_REG_COMPARE);

    assign timer_hit = (compare_q != '0) && (count_q == compare_q);

    // Timer
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q     <= '0;
            compare_q   <= '0;
            timer_int_q <= 1'b0;
        end else begin
            if (write_count) begin
                count_q <= wr_i.data;
            end else begin
                count_q <= count_q + 32'd1;
            end

            if (write_compare) begin
                compare_q   <= wr_i.data;
                timer_int_q <= 1'b0;
            end else if (timer_hit) begin
                timer_int_q <= 1'b1;
            end
        end
    end

    // Status, Cause, EPC, BadVAddr; exception updates override MTC0
    always_ff @(posedge clk) begin
        if (rst) begin
            status_q   <= `CP0_STATUS_RESET;
            cause_q    <= '0;
            epc_q      <= '0;
            badvaddr_q <= '0;
        end else begin
            if (wr_i.we) begin
                case (wr_i.addr)
                    `CP0_REG_STATUS: begin
                        status_q <= (status_q & ~`CP0_STATUS_WMASK) |
                                    (wr_i.data & `CP0_STATUS_WMASK);
                    end
                    `CP0_REG_CAUSE: begin
                        cause_q <= (cause_q & ~`CP0_CAUSE_WMASK) |
                                   (wr_i.data & `CP0_CAUSE_WMASK);
                    end
                    `CP0_REG_EPC: begin
                        epc_q <= wr_i.data;
                    end
                    default: begin
                    end
                endcase
            end

            // IP7 shared with the timer
            cause_q[15:10] <= {int_i[5] | timer_int_q, int_i[4:0]};

            if (take_exc) begin
                status_q[1]  <= 1'b1;
                cause_q[6:2] <= exc_code;
                // Nested exception keeps the first EPC and BD
                if (!status_q[1]) begin
                    epc_q       <= epc_exc;
                    cause_q[31] <= event_i.in_delay_slot;
                end
                if (load_badvaddr) begin
                    badvaddr_q <= event_i.bad_addr;
                end
            end else if (event_i.kind == EXC_ERET) begin
                status_q[1] <= 1'b0;
            end
        end
    end

    // MFC0 read port
    always_comb begin
        case (raddr_i)
            `CP0_REG_BADVADDR: rdata_o = badvaddr_q;
            `CP0_REG_COUNT:    rdata_o = count_q;
            `CP0_REG_COMPARE:  rdata_o = compare_q;
            `CP0_REG_STATUS:   rdata_o = status_q;
            `CP0_REG_CAUSE:    rdata_o = cause_q;
            `CP0_REG_EPC:      rdata_o = epc_q;
            `CP0_REG_PRID:     rdata_o = `CP0_PRID_VALUE;
            `CP0_REG_CONFIG:   rdata_o = `CP0_CONFIG_VALUE;
            default:           rdata_o = '0;
        endcase
    end

    assign status_o    = status_q;
    assign cause_o     = cause_q;
    assign epc_o       = epc_q;
    assign timer_int_o = timer_int_q;

endmodule

//--- hw/cp0_top.sv
`timescale 1ns/1ns

module cp0_top
    import cp0_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  hw_int_t   int_i,
    input  mem_exc_t  mem_i,
    input  cp0_wr_t   wr_i,
    input  cp0_addr_t raddr_i,
    output word_t     rdata_o,
    output logic      flush_o,
    output word_t     new_pc_o,
    output logic      timer_int_o
);

    word_t      status;
    word_t      cause;
    word_t      epc;
    exc_event_t exc_event;

    // Same-cycle decision for the memory stage
    except_resolve u_except_resolve (
        .mem_i    (mem_i),
        .status_i (status),
        .cause_i  (cause),
        .epc_i    (epc),
        .event_o  (exc_event),
        .flush_o  (flush_o),
        .new_pc_o (new_pc_o)
    );

    cp0_reg u_cp0_reg (
        .clk         (clk),
        .rst         (rst),
        .int_i       (int_i),
        .wr_i        (wr_i),
        .raddr_i     (raddr_i),
        .event_i     (exc_event),
        .rdata_o     (rdata_o),
        .status_o    (status),
        .cause_o     (cause),
        .epc_o       (epc),
        .timer_int_o (timer_int_o)
    );

endmodule

//--- hw/except_resolve.sv
`timescale 1ns/1ns

`include "cp0_cfg.svh"

module except_resolve
    import cp0_pkg::*;
(
    input  mem_exc_t   mem_i,
    input  word_t      status_i,
    input  word_t      cause_i,
    input  word_t      epc_i,
    output exc_event_t event_o,
    output logic       flush_o,
    output word_t      new_pc_o
);

    logic      status_ie;
    logic      status_exl;
    logic [5:0] int_mask;
    logic [5:0] int_req;
    logic      int_pending;
    exc_type_t kind;
    word_t     bad_addr;

    assign status_ie  = status_i[0];
    assign status_exl = status_i[1];

    // IM[7:2] against IP[7:2]
    assign int_mask = status_i[15:10];
    assign int_req  = cause_i[15:10];

    assign int_pending = status_ie & ~status_exl & (|(int_req & int_mask));

    // Interrupt first, then instruction exceptions, eret last
    always_comb begin
        kind = EXC_NONE;
        if (mem_i.valid) begin
            if (int_pending) begin
                kind = EXC_INT;
            end else if (mem_i.adel_if) begin
                kind = EXC_ADEL_IF;
            end else if (mem_i.ri) begin
                kind = EXC_RI;
            end else if (mem_i.ov) begin
                kind = EXC_OV;
            end else if (mem_i.trap) begin
                kind = EXC_TR;
            end else if (mem_i.syscall) begin
                kind = EXC_SYS;
            end else if (mem_i.brk) begin
                kind = EXC_BP;
            end else if (mem_i.adel) begin
                kind = EXC_ADEL;
            end else if (mem_i.ades) begin
                kind = EXC_ADES;
            end else if (mem_i.eret) begin
                kind = EXC_ERET;
            end
        end
    end

    // Faulting address for the address errors
    always_comb begin
        case (kind)
            EXC_ADEL_IF: begin
                bad_addr = mem_i.pc;
            end
            EXC_ADEL, EXC_ADES: begin
                bad_addr = mem_i.mem_addr;
            end
            default: begin
                bad_addr = '0;
            end
        endcase
    end

    always_comb begin
        event_o.kind          = kind;
        event_o.pc            = mem_i.pc;
        event_o.in_delay_slot = mem_i.in_delay_slot;
        event_o.bad_addr      = bad_addr;
    end

    assign flush_o = (kind != EXC_NONE);

    // Eret returns through EPC, all else to the vector
    always_comb begin
        if (kind == EXC_ERET) begin
            new_pc_o = epc_i;
        end else begin
            new_pc_o = `CP0_EXC_VECTOR;
        end
    end

endmodule

//--- verification/cp0_tb.sv
`timescale 1ns/1ns

`include "cp0_cfg.svh"

module cp0_tb
    import cp0_pkg::*;
();

    localparam int    CLK_PERIOD   = 4;
    localparam word_t STATUS_WMASK = 32'h0000FF03;
    localparam word_t CAUSE_WMASK  = 32'h00C00300;
    localparam word_t STATUS_EXL   = 32'h00000002;
    localparam word_t ST_BASE      = `CP0_STATUS_RESET;

    // Flag order matches mem_exc_t: adel_if adel ades syscall brk ri ov trap eret
    localparam logic [8:0] F_NONE    = 9'h000;
    localparam logic [8:0] F_ADEL_IF = 9'h100;
    localparam logic [8:0] F_ADEL    = 9'h080;
    localparam logic [8:0] F_ADES    = 9'h040;
    localparam logic [8:0] F_SYS     = 9'h020;
    localparam logic [8:0] F_BP      = 9'h010;
    localparam logic [8:0] F_RI      = 9'h008;
    localparam logic [8:0] F_OV      = 9'h004;
    localparam logic [8:0] F_TR      = 9'h002;
    localparam logic [8:0] F_ERET    = 9'h001;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_WRITE,
        OP_READ,
        OP_INSN,
        OP_LINES
    } op_t;

    typedef struct packed {
        op_t        op;
        cp0_addr_t  addr;
        word_t      data;
        logic [8:0] flags;
        logic       ds;
        word_t      pc;
        word_t      mem_addr;
        hw_int_t    lines;
        word_t      exp_rdata;
        logic       exp_flush;
        word_t      exp_pc;
        logic       exp_timer;
    } step_t;

    logic      clk;
    logic      rst;
    hw_int_t   int_lines;
    mem_exc_t  mem;
    cp0_wr_t   wr;
    cp0_addr_t raddr;
    word_t     rdata;
    logic      flush;
    word_t     new_pc;
    logic      timer_int;

    step_t steps[$];
    int    errors;
    int    checks;
    int    seed;
    logic  timer_now;
    logic  table_ready;

    cp0_top UUT (
        .clk         (clk),
        .rst         (rst),
        .int_i       (int_lines),
        .mem_i       (mem),
        .wr_i        (wr),
        .raddr_i     (raddr),
        .rdata_o     (rdata),
        .flush_o     (flush),
        .new_pc_o    (new_pc),
        .timer_int_o (timer_int)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic step_t blank_step();
        step_t s;
        s = '0;
        s.op = OP_IDLE;
        s.exp_timer = timer_now;
        return s;
    endfunction

    task automatic idle_cycle();
        steps.push_back(blank_step());
    endtask

    task automatic mtc0_write(input cp0_addr_t addr, input word_t data);
        step_t s;
        s = blank_step();
        s.op = OP_WRITE;
        s.addr = addr;
        s.data = data;
        steps.push_back(s);
    endtask

    task automatic mfc0_expect(input cp0_addr_t addr, input word_t expected);
        step_t s;
        s = blank_step();
        s.op = OP_READ;
        s.addr = addr;
        s.exp_rdata = expected;
        steps.push_back(s);
    endtask

    task automatic retire_insn(input logic [8:0] flags, input word_t pc, input logic ds,
                               input word_t mem_addr, input logic exp_flush,
                               input word_t exp_pc);
        step_t s;
        s = blank_step();
        s.op = OP_INSN;
        s.flags = flags;
        s.pc = pc;
        s.ds = ds;
        s.mem_addr = mem_addr;
        s.exp_flush = exp_flush;
        s.exp_pc = exp_pc;
        steps.push_back(s);
    endtask

    task automatic drive_lines(input hw_int_t lines);
        step_t s;
        s = blank_step();
        s.op = OP_LINES;
        s.lines = lines;
        steps.push_back(s);
    endtask

    // Take one exception from EXL=0, inspect CP0, then return with eret
    task automatic exception_case(input logic [8:0] flags, input word_t pc, input logic ds,
                                  input word_t mem_addr, input exc_code_t code,
                                  input logic chk_badv, input word_t badv);
        word_t epc_exp;
        epc_exp = ds ? (pc - 32'd4) : pc;
        retire_insn(flags, pc, ds, mem_addr, 1'b1, `CP0_EXC_VECTOR);
        mfc0_expect(`CP0_REG_STATUS, ST_BASE | STATUS_EXL);
        mfc0_expect(`CP0_REG_CAUSE, {ds, 24'h0, code, 2'b00});
        mfc0_expect(`CP0_REG_EPC, epc_exp);
        if (chk_badv) begin
            mfc0_expect(`CP0_REG_BADVADDR, badv);
        end
        retire_insn(F_ERET, pc + 32'h100, 1'b0, '0, 1'b1, epc_exp);
        mfc0_expect(`CP0_REG_STATUS, ST_BASE);
    endtask

    task automatic build_table();
        word_t status_data;
        word_t cause_data;
        word_t epc_data;
        word_t compare_data;
        word_t count_data;
        status_data = $urandom();
        cause_data = $urandom();
        epc_data = $urandom();
        // Kept far above any Count value reached before it is cleared
        compare_data = $urandom() | 32'h80000000;
        count_data = $urandom() & 32'h0FFFFFFF;

        mfc0_expect(`CP0_REG_STATUS, ST_BASE);
        mfc0_expect(`CP0_REG_CAUSE, 32'h0);
        mtc0_write(`CP0_REG_STATUS, status_data);
        mfc0_expect(`CP0_REG_STATUS, (ST_BASE & ~STATUS_WMASK) | (status_data & STATUS_WMASK));
        mtc0_write(`CP0_REG_CAUSE, cause_data);
        mfc0_expect(`CP0_REG_CAUSE, cause_data & CAUSE_WMASK);
        mtc0_write(`CP0_REG_EPC, epc_data);
        mfc0_expect(`CP0_REG_EPC, epc_data);
        mtc0_write(`CP0_REG_COMPARE, compare_data);
        mfc0_expect(`CP0_REG_COMPARE, compare_data);
        mtc0_write(`CP0_REG_PRID, ~`CP0_PRID_VALUE);
        mfc0_expect(`CP0_REG_PRID, `CP0_PRID_VALUE);
        mtc0_write(`CP0_REG_CONFIG, $urandom());
        mfc0_expect(`CP0_REG_CONFIG, `CP0_CONFIG_VALUE);
        mtc0_write(`CP0_REG_BADVADDR, $urandom());
        mfc0_expect(`CP0_REG_BADVADDR, 32'h0);
        mfc0_expect(5'd3, 32'h0);
        mfc0_expect(5'd31, 32'h0);

        // Count after five idle edges
        mtc0_write(`CP0_REG_COUNT, count_data);
        repeat (5) idle_cycle();
        mfc0_expect(`CP0_REG_COUNT, count_data + 32'd5);

        mtc0_write(`CP0_REG_STATUS, 32'h0);
        mtc0_write(`CP0_REG_CAUSE, 32'h0);
        mtc0_write(`CP0_REG_COMPARE, 32'h0);
        mfc0_expect(`CP0_REG_STATUS, ST_BASE);

        exception_case(F_ADEL_IF, 32'h80001001, 1'b0, '0, ADEL, 1'b1, 32'h80001001);
        exception_case(F_RI, 32'h80002000, 1'b1, '0, RI, 1'b0, '0);
        exception_case(F_OV, 32'h80003000, 1'b0, '0, OV, 1'b0, '0);
        exception_case(F_TR, 32'h80004004, 1'b1, '0, TR, 1'b0, '0);
        exception_case(F_SYS, 32'h80005000, 1'b0, '0, SYS, 1'b0, '0);
        exception_case(F_BP, 32'h80006000, 1'b1, '0, BP, 1'b0, '0);
        exception_case(F_ADEL, 32'h80007000, 1'b0, 32'h12345679, ADEL, 1'b1, 32'h12345679);
        exception_case(F_ADES, 32'h80008000, 1'b1, 32'h00000ABE, ADES, 1'b1, 32'h00000ABE);

        // Several flags at once
        exception_case(F_ADES | F_ADEL | F_BP | F_SYS, 32'h80008100, 1'b0, 32'h5, SYS,
                       1'b0, '0);
        exception_case(F_TR | F_OV | F_RI, 32'h80008200, 1'b0, '0, RI, 1'b0, '0);
        exception_case(F_TR | F_OV, 32'h80008400, 1'b0, '0, OV, 1'b0, '0);
        exception_case(F_SYS | F_TR, 32'h80008500, 1'b0, '0, TR, 1'b0, '0);
        exception_case(F_ADEL | F_BP, 32'h80008600, 1'b0, 32'h7, BP, 1'b0, '0);
        exception_case(F_ADES | F_ADEL, 32'h80008300, 1'b0, 32'h40000003, ADEL, 1'b1,
                       32'h40000003);
        exception_case(F_ERET | F_ADES, 32'h80008700, 1'b0, 32'h20000001, ADES, 1'b1,
                       32'h20000001);
        exception_case(F_ADEL_IF | F_ERET | F_BP, 32'h80009002, 1'b0, '0, ADEL, 1'b1,
                       32'h80009002);
        exception_case(F_BP | F_ERET, 32'h80009100, 1'b1, '0, BP, 1'b0, '0);

        // Second exception while EXL is set
        retire_insn(F_OV, 32'h8000A010, 1'b1, '0, 1'b1, `CP0_EXC_VECTOR);
        retire_insn(F_SYS, 32'h8000B000, 1'b0, '0, 1'b1, `CP0_EXC_VECTOR);
        mfc0_expect(`CP0_REG_CAUSE, {1'b1, 24'h0, SYS, 2'b00});
        mfc0_expect(`CP0_REG_EPC, 32'h8000A00C);
        mfc0_expect(`CP0_REG_STATUS, ST_BASE | STATUS_EXL);
        retire_insn(F_ERET, 32'h8000B100, 1'b0, '0, 1'b1, 32'h8000A00C);
        mfc0_expect(`CP0_REG_STATUS, ST_BASE);

        // IP2 raised: blocked by IE=0, by the mask, then by EXL
        drive_lines(6'b000001);
        mtc0_write(`CP0_REG_STATUS, 32'h00000400);
        retire_insn(F_NONE, 32'h8000C000, 1'b0, '0, 1'b0, '0);
        mtc0_write(`CP0_REG_STATUS, 32'h00000801);
        retire_insn(F_NONE, 32'h8000C004, 1'b0, '0, 1'b0, '0);
        mtc0_write(`CP0_REG_STATUS, 32'h00000403);
        retire_insn(F_NONE, 32'h8000C008, 1'b0, '0, 1'b0, '0);
        mtc0_write(`CP0_REG_STATUS, 32'h00000401);
        retire_insn(F_RI, 32'h8000C00C, 1'b0, '0, 1'b1, `CP0_EXC_VECTOR);
        mfc0_expect(`CP0_REG_CAUSE, 32'h00000400);
        mfc0_expect(`CP0_REG_STATUS, ST_BASE | 32'h00000403);
        mfc0_expect(`CP0_REG_EPC, 32'h8000C00C);
        drive_lines(6'b000000);
        retire_insn(F_ERET, 32'h8000C100, 1'b0, '0, 1'b1, 32'h8000C00C);
        mtc0_write(`CP0_REG_STATUS, 32'h0);
        mfc0_expect(`CP0_REG_CAUSE, 32'h0);

        // Compare match three edges after the Compare write
        mtc0_write(`CP0_REG_COUNT, 32'h100);
        mtc0_write(`CP0_REG_COMPARE, 32'h103);
        mfc0_expect(`CP0_REG_COUNT, 32'h101);
        mfc0_expect(`CP0_REG_COUNT, 32'h102);
        mfc0_expect(`CP0_REG_COUNT, 32'h103);
        timer_now = 1'b1;
        idle_cycle();
        idle_cycle();
        mtc0_write(`CP0_REG_COMPARE, 32'h0);
        timer_now = 1'b0;
        idle_cycle();
        mfc0_expect(`CP0_REG_COMPARE, 32'h0);
    endtask

    task automatic apply_step(input step_t s);
        wr = '0;
        mem = '0;
        case (s.op)
            OP_WRITE: begin
                wr.we = 1'b1;
                wr.addr = s.addr;
                wr.data = s.data;
            end
            OP_READ: begin
                raddr = s.addr;
            end
            OP_INSN: begin
                mem.valid = 1'b1;
                mem.pc = s.pc;
                mem.in_delay_slot = s.ds;
                mem.mem_addr = s.mem_addr;
                {mem.adel_if, mem.adel, mem.ades, mem.syscall, mem.brk,
                 mem.ri, mem.ov, mem.trap, mem.eret} = s.flags;
            end
            OP_LINES: begin
                int_lines = s.lines;
            end
            default: begin
            end
        endcase
    endtask

    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        errors++;
        $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic check_step(input step_t s);
        if (s.op == OP_READ) begin
            checks++;
            if (rdata !== s.exp_rdata) begin
                report_mismatch("rdata_o", s.exp_rdata, rdata);
            end
        end
        checks++;
        if (flush !== s.exp_flush) begin
            report_mismatch("flush_o", {31'b0, s.exp_flush}, {31'b0, flush});
        end
        if (s.exp_flush) begin
            checks++;
            if (new_pc !== s.exp_pc) begin
                report_mismatch("new_pc_o", s.exp_pc, new_pc);
            end
        end
        checks++;
        if (timer_int !== s.exp_timer) begin
            report_mismatch("timer_int_o", {31'b0, s.exp_timer}, {31'b0, timer_int});
        end
    endtask

    initial begin
        int i;
        rst = 1'b1;
        int_lines = '0;
        mem = '0;
        wr = '0;
        raddr = '0;
        errors = 0;
        checks = 0;
        timer_now = 1'b0;
        table_ready = 1'b0;
        seed = 5152;
        void'($urandom(seed));
        build_table();
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < steps.size(); i++) begin
            @(negedge clk);
            apply_step(steps[i]);
            #1;
            check_step(steps[i]);
        end
        @(negedge clk);

        $display("Summary: %0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Four cycles of budget per table step
    initial begin
        int limit;
        wait (table_ready);
        limit = steps.size() * 4 * CLK_PERIOD + 200;
        #(limit);
        $display("Timeout: the step table did not complete within %0d ns", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/cp0_pkg.sv
hw/except_resolve.sv
hw/cp0_reg.sv
hw/cp0_top.sv
verification/cp0_tb.sv
